// File: Makefile
TOP = dual_decode_tb
LOG = sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f dual_decode_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dual_decode_top.f
+incdir+include
verilog/dual_decode_pkg.sv
verilog/stage_reg.sv
verilog/instr_decoder.sv
verilog/decode_stage.sv
verilog/register_read_stage.sv
verilog/dual_decode_top.sv
sim/dual_decode_tb.sv

// File: include/dual_decode_config.svh
`ifndef DUAL_DECODE_CONFIG_SVH
`define DUAL_DECODE_CONFIG_SVH

// ********************
// core sizes
// ********************

`define DD_XLEN 32     // data and pc width
`define DD_NREGS 32    // integer register count
`define DD_RADDR_W 5   // register address width

`endif

// File: sim/dual_decode_tb.sv
`default_nettype none

module dual_decode_tb import dual_decode_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam wb_t no_wb = '0;

  logic clock;
  logic reset;
  fetch_pair_t fetch;
  logic flush;
  wb_t wb;
  issue_pair_t issue;
  logic fetch_stall;

  logic [31:0] lfsr;
  logic [31:0] shadow [32];  // register file model
  int checks;
  int value_errors;
  int timeouts;

  dual_decode_top i_dut (
    .clock(clock),
    .reset(reset),
    .fetch(fetch),
    .flush(flush),
    .wb(wb),
    .issue(issue),
    .fetch_stall(fetch_stall)
  );

  always #4 clock = ~clock;

  // ********************
  // helpers
  // ********************

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // expected decode from the RV32I encoding rules
  function automatic decoded_slot_t ref_decode(input logic [31:0] ins, input logic [31:0] pc,
      input bit sys_ok);
    decoded_slot_t s;
    logic [6:0] f7;
    logic bad;
    s = '0;
    f7 = ins[31:25];
    bad = 1'b0;
    s.valid = 1'b1;
    s.pc = pc;
    s.funct3 = ins[14:12];
    s.funct7_5 = ins[30];
    s.rd = ins[11:7];
    s.rs1 = ins[19:15];
    s.rs2 = ins[24:20];
    case (ins[6:0])
      7'h33: begin
        s.op = op_alu_reg;
        {s.wren, s.rden1, s.rden2} = 3'b111;
        bad = !(f7 == 7'h00 || (f7 == 7'h20 && (s.funct3 == 3'd0 || s.funct3 == 3'd5)));
      end
      7'h13: begin
        s.op = op_alu_imm;
        {s.wren, s.rden1} = 2'b11;
        s.imm = {{20{ins[31]}}, ins[31:20]};
        bad = (s.funct3 == 3'd1 && f7 != 7'h00) ||
              (s.funct3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);  // shift amount checks
      end
      7'h37: begin
        s.op = op_lui;
        s.wren = 1'b1;
        s.imm = {ins[31:12], 12'h000};
      end
      7'h63: begin
        s.op = op_branch;
        {s.rden1, s.rden2} = 2'b11;
        s.imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        bad = (s.funct3 == 3'd2 || s.funct3 == 3'd3);
      end
      7'h03: begin
        s.op = op_load;
        {s.wren, s.rden1} = 2'b11;
        s.imm = {{20{ins[31]}}, ins[31:20]};
        bad = (s.funct3 == 3'd3 || s.funct3 >= 3'd6);
      end
      7'h23: begin
        s.op = op_store;
        {s.rden1, s.rden2} = 2'b11;
        s.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        bad = (s.funct3 > 3'd2);
      end
      7'h73: begin
        s.op = op_system;
        bad = !sys_ok || (ins != 32'h0000_0073 && ins != 32'h0010_0073);
        s.cause = (ins == 32'h0000_0073) ? exc_env_call : exc_breakpoint;
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      s.cause = exc_illegal;
    end
    if (s.cause != exc_none) begin
      s.etval = ins;
      s.wren = 1'b0;                // a trapping slot never writes
    end
    return s;
  endfunction

  function automatic issue_slot_t expect_slot(input logic [31:0] ins, input logic [31:0] pc,
      input bit sys_ok);
    issue_slot_t e;
    e.dec = ref_decode(ins, pc, sys_ok);
    e.rs1_data = e.dec.rden1 ? shadow[e.dec.rs1] : '0;  // shadow[0] stays zero
    e.rs2_data = e.dec.rden2 ? shadow[e.dec.rs2] : '0;
    return e;
  endfunction

  // ********************
  // compare tasks
  // ********************

  task automatic check_slot(input string name, input issue_slot_t exp, input issue_slot_t act);
    checks++;
    if (act.dec !== exp.dec) begin
      value_errors++;
      $display("Error %s decode: expected %h actual %h", name, exp.dec, act.dec);
    end
    if (act.rs1_data !== exp.rs1_data || act.rs2_data !== exp.rs2_data) begin
      value_errors++;
      $display("Error %s operands: expected %h %h actual %h %h", name,
               exp.rs1_data, exp.rs2_data, act.rs1_data, act.rs2_data);
    end
  endtask

  task automatic check_cause(input string name, input except_t exp, input except_t act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("Error %s cause: expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("Error %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      value_errors++;
      $display("Error %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  // ********************
  // drivers
  // ********************

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic wait_issue(input string name, input int limit, output bit seen,
      output int edges);
    seen = 1'b0;
    edges = 0;
    while (edges < limit && !seen) begin
      step();
      wb = no_wb;
      edges++;
      seen = issue.slot0.dec.valid || issue.slot1.dec.valid;
    end
    if (!seen) begin
      timeouts++;
      $display("%s: no valid issue pair within %0d cycles", name, limit);
    end
  endtask

  // mid is applied in the cycle the pair is read
  task automatic send_pair(input string name, input logic [31:0] i0, input logic [31:0] i1,
      input logic [31:0] pc, input wb_t mid);
    issue_slot_t e0;
    issue_slot_t e1;
    bit seen;
    int edges;
    fetch = '{valid: 1'b1, pc: pc, instr0: i0, instr1: i1};
    step();
    fetch = fetch_bubble;
    step();
    wb = mid;
    if (mid.wren && mid.waddr != 5'd0) begin
      shadow[mid.waddr] = mid.wdata;
    end
    e0 = expect_slot(i0, pc, 1'b1);
    e1 = expect_slot(i1, pc + 32'd4, 1'b0);
    wait_issue(name, 8, seen, edges);
    if (seen) begin
      check_count({name, " latency"}, 3, 2 + edges);  // fetch to issue in three edges
      check_slot({name, " slot0"}, e0, issue.slot0);
      check_slot({name, " slot1"}, e1, issue.slot1);
    end
  endtask

  // ********************
  // tests
  // ********************

  // pairs in flight when reset hits must never issue
  task automatic reset_test();
    fetch = '{valid: 1'b1, pc: 32'h0000_0300, instr0: enc_i(12'h001, 5'd1, 3'd0, 5'd1, 7'h13),
              instr1: 32'h0000_0013};
    step();
    fetch.pc = 32'h0000_0308;
    step();
    reset = 1'b0;
    step();
    reset = 1'b1;
    fetch = fetch_bubble;
    for (int n = 0; n < 4; n++) begin
      check_bit("reset issue valid", 1'b0, issue.slot0.dec.valid | issue.slot1.dec.valid);
      check_bit("reset fetch_stall", 1'b0, fetch_stall);
      step();
    end
  endtask

  task automatic init_regs();
    for (int r = 0; r < 32; r++) begin
      wb = '{wren: 1'b1, waddr: 5'(r), wdata: rand_bits(32)};
      if (r != 0) begin
        shadow[r] = wb.wdata;       // the write to x0 is dropped
      end
      step();
    end
    wb = no_wb;
  endtask

  task automatic decode_test();
    send_pair("alu_reg", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd10),
              enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd11), 32'h0000_0100, no_wb);
    send_pair("alu_imm", enc_i(12'hff9, 5'd5, 3'd0, 5'd12, 7'h13),
              enc_i(12'h403, 5'd6, 3'd5, 5'd13, 7'h13), 32'h0000_0108, no_wb);  // srai
    send_pair("lui_branch", {20'habcde, 5'd14, 7'h37},
              32'hfe74_08e3, 32'h0000_0110, no_wb);  // beq x8, x7, -16
    // sw x9, 12(x10) with x9 written in the read cycle, then add x15, x0, x9
    send_pair("store_wt", 32'h0095_2623, enc_r(7'h00, 5'd9, 5'd0, 3'd0, 5'd15),
              32'h0000_0118, '{wren: 1'b1, waddr: 5'd9, wdata: 32'h1234_5678});
    // x0 written in the read cycle still reads zero
    send_pair("x0_wt", enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd16),
              enc_i(12'h005, 5'd0, 3'd0, 5'd17, 7'h13), 32'h0000_0120,
              '{wren: 1'b1, waddr: 5'd0, wdata: 32'hdead_beef});
  endtask

  task automatic exceptions_test();
    send_pair("undefined", 32'hffff_ffff, 32'h0000_0013, 32'h0000_0200, no_wb);
    check_cause("undefined", exc_illegal, issue.slot0.dec.cause);
    check_bit("undefined wren", 1'b0, issue.slot0.dec.wren);
    send_pair("ecall", 32'h0000_0073, 32'h0000_0073, 32'h0000_0208, no_wb);
    check_cause("ecall slot0", exc_env_call, issue.slot0.dec.cause);
    check_cause("ecall slot1", exc_illegal, issue.slot1.dec.cause);
    check_bit("ecall wren", 1'b0, issue.slot0.dec.wren | issue.slot1.dec.wren);
    send_pair("ebreak", 32'h0010_0073, 32'h0000_0013, 32'h0000_0210, no_wb);
    check_cause("ebreak", exc_breakpoint, issue.slot0.dec.cause);
    check_bit("ebreak wren", 1'b0, issue.slot0.dec.wren);
  endtask

  // lw x5 pair followed by (j0, j1)
  task automatic load_use(input string name, input logic [31:0] j0, input logic [31:0] j1,
      input int exp_stalls);
    issue_pair_t seen_q[$];
    issue_slot_t l0;
    issue_slot_t l1;
    logic [31:0] ld0;
    logic [31:0] ld1;
    int stalls;
    int first;
    ld0 = enc_i(12'h010, 5'd1, 3'd2, 5'd5, 7'h03);
    ld1 = enc_i(12'h001, 5'd2, 3'd0, 5'd6, 7'h13);
    l0 = expect_slot(ld0, 32'h0000_0400, 1'b1);
    l1 = expect_slot(ld1, 32'h0000_0404, 1'b0);
    stalls = 0;
    first = -1;
    fetch = '{valid: 1'b1, pc: 32'h0000_0400, instr0: ld0, instr1: ld1};
    step();
    fetch = '{valid: 1'b1, pc: 32'h0000_0408, instr0: j0, instr1: j1};
    for (int i = 0; i < 10; i++) begin
      step();
      if (fetch_stall) begin
        stalls++;                   // fetch keeps the same pair
      end else begin
        fetch = fetch_bubble;
      end
      seen_q.push_back(issue);
    end
    check_count({name, " stall cycles"}, exp_stalls, stalls);
    foreach (seen_q[i]) begin
      if (first < 0 && seen_q[i].slot0.dec.valid) begin
        first = i;
      end
    end
    if (first < 0 || first + exp_stalls + 1 >= seen_q.size()) begin
      timeouts++;
      $display("%s: load pair or dependent pair never issued", name);
    end else begin
      check_slot({name, " load slot0"}, l0, seen_q[first].slot0);
      check_slot({name, " load slot1"}, l1, seen_q[first].slot1);
      for (int k = 1; k <= exp_stalls; k++) begin
        check_bit({name, " gap valid"}, 1'b0,
                  seen_q[first + k].slot0.dec.valid | seen_q[first + k].slot1.dec.valid);
      end
      check_slot({name, " next slot0"}, expect_slot(j0, 32'h0000_0408, 1'b1),
                 seen_q[first + exp_stalls + 1].slot0);
      check_slot({name, " next slot1"}, expect_slot(j1, 32'h0000_040c, 1'b0),
                 seen_q[first + exp_stalls + 1].slot1);
    end
  endtask

  task automatic flush_test();
    issue_slot_t e0;
    issue_slot_t e1;
    bit seen;
    int edges;
    for (int n = 0; n < 3; n++) begin
      fetch = '{valid: 1'b1, pc: 32'h0000_0500 + 32'(n) * 8,
                instr0: enc_i(12'(n), 5'd1, 3'd0, 5'd20, 7'h13), instr1: 32'h0000_0013};
      flush = (n == 2);
      step();
      check_bit("flush issue valid", 1'b0, issue.slot0.dec.valid | issue.slot1.dec.valid);
    end
    flush = 1'b0;
    fetch = '{valid: 1'b1, pc: 32'h0000_0580, instr0: enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd21),
              instr1: 32'h0000_0013};
    e0 = expect_slot(fetch.instr0, 32'h0000_0580, 1'b1);
    e1 = expect_slot(fetch.instr1, 32'h0000_0584, 1'b0);
    step();
    fetch = fetch_bubble;
    check_bit("flush drained", 1'b0, issue.slot0.dec.valid | issue.slot1.dec.valid);
    wait_issue("flush", 8, seen, edges);
    if (seen) begin
      check_count("flush latency", 3, 1 + edges);
      check_slot("flush slot0", e0, issue.slot0);  // first valid pair must be the new one
      check_slot("flush slot1", e1, issue.slot1);
    end
  endtask

  task automatic random_test();
    logic [31:0] i0;
    logic [31:0] i1;
    for (int n = 0; n < 200; n++) begin
      i0 = enc_i(12'(rand_bits(12)), 5'(rand_bits(5)), 3'(rand_bits(3)), 5'(rand_bits(5)),
                 7'h13);
      i1 = enc_i(12'(rand_bits(12)), 5'(rand_bits(5)), 3'(rand_bits(3)), 5'(rand_bits(5)),
                 7'h13);
      send_pair($sformatf("random %0d", n), i0, i1, 32'h0000_1000 + 32'(n) * 8, no_wb);
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    fetch = fetch_bubble;
    flush = 1'b0;
    wb = no_wb;
    lfsr = 32'h4f7e;
    checks = 0;
    value_errors = 0;
    timeouts = 0;
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b1;
    step();
    reset_test();
    init_regs();
    decode_test();
    exceptions_test();
    load_use("load_use", enc_r(7'h00, 5'd3, 5'd5, 3'd0, 5'd7),
             enc_i(12'h002, 5'd4, 3'd0, 5'd8, 7'h13), 1);
    load_use("no_dep", enc_r(7'h00, 5'd4, 5'd3, 3'd0, 5'd7),
             enc_i(12'h002, 5'd6, 3'd0, 5'd8, 7'h13), 0);
    flush_test();
    random_test();
    $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

module decode_stage import dual_decode_pkg::*; (
  input fetch_pair_t fd,
  input decoded_pair_t di,
  output decoded_pair_t decoded,
  output logic stall
);

  decoded_slot_t dec0;
  decoded_slot_t dec1;
  logic [3:0] hit;

  // load in di against a reader in fd
  function automatic logic load_hit(
    input decoded_slot_t ld,
    input decoded_slot_t rd_slot
  );
    logic ld_ok;
    logic use1;
    logic use2;
    ld_ok = ld.valid && ld.op == op_load && ld.wren && ld.rd != '0;
    use1 = rd_slot.rden1 && rd_slot.rs1 == ld.rd;
    use2 = rd_slot.rden2 && rd_slot.rs2 == ld.rd;
    return ld_ok && rd_slot.valid && (use1 || use2);
  endfunction

  // ********************
  // slot decoders
  // ********************

  instr_decoder #(
    .allow_system(1'b1)
  ) i_decoder0 (
    .instr(fd.instr0),
    .slot(dec0)
  );

  instr_decoder #(
    .allow_system(1'b0)
  ) i_decoder1 (
    .instr(fd.instr1),
    .slot(dec1)
  );

  always_comb begin
    decoded = decoded_bubble;
    if (fd.valid) begin
      decoded.slot0 = dec0;
      decoded.slot0.valid = 1'b1;
      decoded.slot0.pc = fd.pc;
      decoded.slot1 = dec1;
      decoded.slot1.valid = 1'b1;
      decoded.slot1.pc = fd.pc + 32'd4;
      if (decoded.slot0.cause != exc_none) begin
        decoded.slot0.wren = 1'b0;  // trapping slot never writes
      end
      if (decoded.slot1.cause != exc_none) begin
        decoded.slot1.wren = 1'b0;
      end
    end
  end

  // ********************
  // load-use hazard
  // ********************

  assign hit[0] = load_hit(di.slot0, decoded.slot0);
  assign hit[1] = load_hit(di.slot1, decoded.slot0);
  assign hit[2] = load_hit(di.slot0, decoded.slot1);
  assign hit[3] = load_hit(di.slot1, decoded.slot1);

  assign stall = |hit;

  always_comb begin
    a_stall_needs_fd: assert (!(stall && !fd.valid))
      else $error("stall raised without a valid fetch pair");
  end

endmodule

`default_nettype wire

// File: verilog/dual_decode_pkg.sv
`default_nettype none

`include "dual_decode_config.svh"

package dual_decode_pkg;

  // ********************
  // encodings
  // ********************

  typedef enum logic [3:0] {
    op_none,     // bubble
    op_alu_reg,
    op_alu_imm,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_branch,
    op_load,
    op_store,
    op_fence,
    op_system
  } op_class_t;

  typedef enum logic [1:0] {
    exc_none,
    exc_illegal,
    exc_breakpoint,
    exc_env_call
  } except_t;

  // ********************
  // pipeline payloads
  // ********************

  typedef struct packed {
    logic valid;
    logic [`DD_XLEN-1:0] pc;      // slot 1 sits at pc+4
    logic [31:0] instr0;
    logic [31:0] instr1;
  } fetch_pair_t;

  typedef struct packed {
    logic valid;
    op_class_t op;
    logic [2:0] funct3;
    logic funct7_5;                 // sub/sra select
    logic [`DD_RADDR_W-1:0] rd;
    logic [`DD_RADDR_W-1:0] rs1;
    logic [`DD_RADDR_W-1:0] rs2;
    logic wren;
    logic rden1;
    logic rden2;
    logic [`DD_XLEN-1:0] imm;
    logic [`DD_XLEN-1:0] pc;
    except_t cause;
    logic [`DD_XLEN-1:0] etval;
  } decoded_slot_t;

  typedef struct packed {
    decoded_slot_t slot0;
    decoded_slot_t slot1;
  } decoded_pair_t;

  typedef struct packed {
    logic wren;
    logic [`DD_RADDR_W-1:0] waddr;
    logic [`DD_XLEN-1:0] wdata;
  } wb_t;

  typedef struct packed {
    decoded_slot_t dec;
    logic [`DD_XLEN-1:0] rs1_data;
    logic [`DD_XLEN-1:0] rs2_data;
  } issue_slot_t;

  typedef struct packed {
    issue_slot_t slot0;
    issue_slot_t slot1;
  } issue_pair_t;

  localparam fetch_pair_t fetch_bubble = '0;
  localparam decoded_pair_t decoded_bubble = '0;

endpackage

`default_nettype wire

// File: verilog/dual_decode_top.sv
`default_nettype none

module dual_decode_top import dual_decode_pkg::*; (
  input logic clock,
  input logic reset,
  input fetch_pair_t fetch,
  input logic flush,
  input wb_t wb,
  output issue_pair_t issue,
  output logic fetch_stall
);

  fetch_pair_t fd;
  decoded_pair_t decoded;
  decoded_pair_t di;
  logic stall;
  logic di_flush;

  assign di_flush = flush | stall;  // stall drops a bubble into di
  assign fetch_stall = stall;

  stage_reg #(
    .payload_t(fetch_pair_t),
    .bubble(fetch_bubble)
  ) fd_reg (
    .clock(clock),
    .reset(reset),
    .hold(stall),
    .flush(flush),
    .d(fetch),
    .q(fd)
  );

  decode_stage i_decode (
    .fd(fd),
    .di(di),
    .decoded(decoded),
    .stall(stall)
  );

  stage_reg #(
    .payload_t(decoded_pair_t),
    .bubble(decoded_bubble)
  ) di_reg (
    .clock(clock),
    .reset(reset),
    .hold(1'b0),
    .flush(di_flush),
    .d(decoded),
    .q(di)
  );

  register_read_stage i_register_read (
    .clock(clock),
    .reset(reset),
    .flush(flush),
    .di(di),
    .wb(wb),
    .issue(issue)
  );

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`default_nettype none

module instr_decoder import dual_decode_pkg::*; #(
  parameter bit allow_system = 1'b1
) (
  input logic [31:0] instr,
  output decoded_slot_t slot
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic illegal;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    slot = '0;
    illegal = 1'b0;
    slot.funct3 = funct3;
    slot.funct7_5 = instr[30];
    slot.rd = instr[11:7];
    slot.rs1 = instr[19:15];
    slot.rs2 = instr[24:20];
    case (opcode)
      7'b0110011: begin
        slot.op = op_alu_reg;
        {slot.wren, slot.rden1, slot.rden2} = 3'b111;
        if (funct7 != 7'b0000000 &&
            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          illegal = 1'b1;         // only sub and sra use the alternate funct7
        end
      end
      7'b0010011: begin
        slot.op = op_alu_imm;
        {slot.wren, slot.rden1} = 2'b11;
        slot.imm = imm_i;
        if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
          illegal = 1'b1;
        end else if (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000) begin
          illegal = 1'b1;
        end
      end
      7'b0110111: begin
        slot.op = op_lui;
        slot.wren = 1'b1;
        slot.imm = imm_u;
      end
      7'b0010111: begin
        slot.op = op_auipc;
        slot.wren = 1'b1;
        slot.imm = imm_u;
      end
      7'b1101111: begin
        slot.op = op_jal;
        slot.wren = 1'b1;
        slot.imm = imm_j;
      end
      7'b1100111: begin
        slot.op = op_jalr;
        {slot.wren, slot.rden1} = 2'b11;
        slot.imm = imm_i;
        illegal = (funct3 != 3'b000);
      end
      7'b1100011: begin
        slot.op = op_branch;
        {slot.rden1, slot.rden2} = 2'b11;
        slot.imm = imm_b;
        illegal = (funct3 == 3'b010 || funct3 == 3'b011);
      end
      7'b0000011: begin
        slot.op = op_load;
        {slot.wren, slot.rden1} = 2'b11;
        slot.imm = imm_i;
        illegal = (funct3 == 3'b011 || funct3 == 3'b110 || funct3 == 3'b111);
      end
      7'b0100011: begin
        slot.op = op_store;
        {slot.rden1, slot.rden2} = 2'b11;
        slot.imm = imm_s;
        illegal = (funct3 > 3'b010);
      end
      7'b0001111: begin
        slot.op = op_fence;
        illegal = (funct3 != 3'b000);
      end
      7'b1110011: begin
        slot.op = op_system;
        if (!allow_system) begin
          illegal = 1'b1;
        end else if (instr[31:7] == 25'h0000000) begin
          slot.cause = exc_env_call;
        end else if (instr[31:7] == 25'h0002000) begin
          slot.cause = exc_breakpoint;
        end else begin
          illegal = 1'b1;           // no csr access here
        end
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      slot.cause = exc_illegal;
    end
    if (slot.cause != exc_none) begin
      slot.etval = instr;
    end
  end

endmodule

`default_nettype wire

// File: verilog/register_read_stage.sv
`default_nettype none

`include "dual_decode_config.svh"

module register_read_stage import dual_decode_pkg::*; (
  input logic clock,
  input logic reset,
  input logic flush,
  input decoded_pair_t di,
  input wb_t wb,
  output issue_pair_t issue
);

  logic [`DD_XLEN-1:0] regs [`DD_NREGS];
  issue_pair_t issue_d;

  // operand with write-through from the same-cycle writeback
  function automatic logic [`DD_XLEN-1:0] operand(
    input logic en,
    input logic [`DD_RADDR_W-1:0] addr,
    input logic [`DD_XLEN-1:0] stored,
    input wb_t w
  );
    logic [`DD_XLEN-1:0] data;
    data = stored;
    if (!en || addr == '0) begin
      data = '0;
    end else if (w.wren && w.waddr == addr) begin
      data = w.wdata;
    end
    return data;
  endfunction

  // ********************
  // register file
  // ********************

  always_ff @(posedge clock) begin
    if (!reset) begin
      regs[0] <= '0;
    end else if (wb.wren && wb.waddr != '0) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  always_comb begin
    issue_d.slot0.dec = di.slot0;
    issue_d.slot0.rs1_data = operand(di.slot0.rden1, di.slot0.rs1, regs[di.slot0.rs1], wb);
    issue_d.slot0.rs2_data = operand(di.slot0.rden2, di.slot0.rs2, regs[di.slot0.rs2], wb);
    issue_d.slot1.dec = di.slot1;
    issue_d.slot1.rs1_data = operand(di.slot1.rden1, di.slot1.rs1, regs[di.slot1.rs1], wb);
    issue_d.slot1.rs2_data = operand(di.slot1.rden2, di.slot1.rs2, regs[di.slot1.rs2], wb);
  end

  // ********************
  // issue register
  // ********************

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      issue.slot0.dec.valid <= 1'b0;  // payload may keep stale data
      issue.slot1.dec.valid <= 1'b0;
    end else begin
      issue <= issue_d;
    end
  end

  a_x0_zero: assert property (
    @(posedge clock) disable iff (!reset) regs[0] == '0
  ) else $error("x0 was written");

endmodule

`default_nettype wire

// File: verilog/stage_reg.sv
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic,
  parameter payload_t bubble = '0
) (
  input logic clock,
  input logic reset,
  input logic hold,
  input logic flush,
  input payload_t d,
  output payload_t q
);

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      q <= bubble;                  // flush wins over hold
    end else if (!hold) begin
      q <= d;
    end
  end

  // ********************
  // checks
  // ********************

  a_reset_bubble: assert property (
    @(posedge clock) !reset |=> (q == bubble)
  ) else $error("stage_reg not empty after reset");

endmodule

`default_nettype wire
